//--- common/ats21IsaPkg.sv
package ats21IsaPkg;

  ////////////////////////////////////////////////////////////////////////////
  // instruction field widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int clockIdxW = 4;   // up to 16 clocks
  localparam int alarmIdxW = 5;   // up to 24 alarms
  localparam int beatW     = 16;  // one req transfer

  // mode word permission bits, counted inside the target field
  localparam int modeClockPermBit = 3;  // word bit 27
  localparam int modeAlarmPermBit = 1;  // word bit 25

  typedef enum logic [2:0] {
    opNop      = 3'b000,
    opSetClock = 3'b001,
    opEnClock  = 3'b010,
    opSetMode  = 3'b011,
    opSetAlarm = 3'b101,
    opSetTimer = 3'b110,
    opEnAlarm  = 3'b111
  } opcodeT;  // 3'b100 left undefined

  // full 32-bit word, upper beat first
  typedef struct packed {
    opcodeT                opcode;    // 31:29
    logic [alarmIdxW-1:0]  target;    // alarm number, clock number in top 4 bits
    logic                  flag;      // enable / repeat / active
    logic                  rateLo;    // rate is flag and this bit
    logic [1:0]            aux;       // spare
    logic [clockIdxW-1:0]  clockSel;  // clock an alarm runs against
    logic [beatW-1:0]      value;     // count, alarm time or interval
  } instWordT;

  // one client's command after decode
  typedef struct packed {
    opcodeT                opcode;
    logic [clockIdxW-1:0]  clockIdx;
    logic [alarmIdxW-1:0]  alarmIdx;
    logic                  flag;
    logic [1:0]            rate;
    logic [clockIdxW-1:0]  clockSel;
    logic [beatW-1:0]      value;     // absolute expiry for timers
    logic                  accepted;  // passed conflict and permission checks
  } clientCmdT;

endpackage

//--- common/ats21StatePkg.sv
package ats21StatePkg;

  typedef enum logic [1:0] {
    rate1x   = 2'b00,
    rateDiv2 = 2'b01,
    rateDiv4 = 2'b10
  } rateT;  // 2'b11 never ticks

  // one enable per rate, all from clk_1x
  typedef struct packed {
    logic div4;
    logic div2;
    logic x1;
  } tickT;

  // global control register
  typedef struct packed {
    logic active;      // device running
    logic clockPermA;
    logic alarmPermA;
    logic clockPermB;
    logic alarmPermB;
  } modeT;

  typedef enum logic {
    clientA = 1'b0,
    clientB = 1'b1
  } clientIdT;  // also the stat bit position

  ////////////////////////////////////////////////////////////////////////////
  // rate select
  ////////////////////////////////////////////////////////////////////////////

  // true when a clock at this rate advances this cycle
  function automatic logic rateTick(rateT rate, tickT ticks);
    logic hit;
    case (rate)
      rate1x:   hit = ticks.x1;
      rateDiv2: hit = ticks.div2;
      rateDiv4: hit = ticks.div4;
      default:  hit = 1'b0;
    endcase
    return hit;
  endfunction

endpackage

//--- rtl/clientCapture.sv
module clientCapture (
  input  logic                           clk_1x,
  input  logic                           reset,
  input  logic                           req,
  input  logic [ats21IsaPkg::beatW-1:0]  beat,
  output ats21IsaPkg::instWordT          word,
  output logic                           wordValid,  // lower-half cycle
  output logic                           busy        // between beats
);

  logic                           pending;  // upper half held
  logic [ats21IsaPkg::beatW-1:0]  upper;

  // upper half needs req, an idle client and a non-zero opcode
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (!pending && req && (beat[15:13] != 3'b000)) begin
      pending <= 1'b1;
    end else begin
      pending <= 1'b0;  // lower half taken whatever req is
    end
  end

  // payload only, follows pending
  always_ff @(posedge clk_1x) begin
    if (!pending && req) begin
      upper <= beat;
    end
  end

  // stored upper half joined with the live beat
  always_comb begin
    if (pending) begin
      word = {upper, beat};
    end else begin
      word = '0;  // reads as Nop
    end
  end

  assign wordValid = pending;
  assign busy      = pending;

endmodule

//--- rtl/instDecode.sv
module instDecode #(
  parameter int numClocks    = 16,
  parameter int counterWidth = 16
) (
  input  ats21IsaPkg::instWordT                  wordA,
  input  ats21IsaPkg::instWordT                  wordB,
  input  logic                                   validA,
  input  logic                                   validB,
  input  ats21StatePkg::modeT                    mode,
  input  logic [numClocks-1:0][counterWidth-1:0] counts,
  output ats21IsaPkg::clientCmdT                 cmdA,
  output ats21IsaPkg::clientCmdT                 cmdB
);

  logic sameOp, clockClash, alarmClash, modeClash, crossClash;
  logic conflict;
  logic [counterWidth-1:0] baseA, baseB;  // clock count a timer starts from

  ////////////////////////////////////////////////////////////////////////////
  // opcode classes
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic isClockOp(ats21IsaPkg::opcodeT op);
    return (op == ats21IsaPkg::opSetClock) || (op == ats21IsaPkg::opEnClock);
  endfunction

  function automatic logic isAlarmOp(ats21IsaPkg::opcodeT op);
    return (op == ats21IsaPkg::opSetAlarm) || (op == ats21IsaPkg::opSetTimer) ||
           (op == ats21IsaPkg::opEnAlarm);
  endfunction

  // builds one command, accepted bit last
  function automatic ats21IsaPkg::clientCmdT formCmd(
    ats21IsaPkg::instWordT   w,
    logic                    valid,
    logic                    clockPerm,
    logic                    alarmPerm,
    logic                    clash,
    logic [counterWidth-1:0] base
  );
    ats21IsaPkg::clientCmdT c;
    logic                   permOk;
    c.opcode   = w.opcode;
    c.clockIdx = w.target[ats21IsaPkg::alarmIdxW-1 -: ats21IsaPkg::clockIdxW];
    c.alarmIdx = w.target;
    c.flag     = w.flag;
    c.rate     = {w.flag, w.rateLo};
    c.clockSel = w.clockSel;
    if (w.opcode == ats21IsaPkg::opSetTimer) begin
      c.value = w.value + ats21IsaPkg::beatW'(base);  // absolute expiry
    end else begin
      c.value = w.value;
    end
    if (isClockOp(w.opcode)) begin
      permOk = clockPerm;
    end else if (isAlarmOp(w.opcode)) begin
      permOk = alarmPerm;
    end else begin
      permOk = (w.opcode == ats21IsaPkg::opSetMode);  // Nop and undefined fail here
    end
    c.accepted = valid && !clash && permOk;
    return c;
  endfunction

  assign baseA = counts[wordA.clockSel];
  assign baseB = counts[wordB.clockSel];

  ////////////////////////////////////////////////////////////////////////////
  // conflict between clients
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sameOp     = (wordA.opcode == wordB.opcode);
    clockClash = sameOp && isClockOp(wordA.opcode) &&
                 (wordA.target[4:1] == wordB.target[4:1]);  // clock field only
    alarmClash = sameOp && isAlarmOp(wordA.opcode) && (wordA.target == wordB.target);
    modeClash  = (wordA.opcode == ats21IsaPkg::opSetMode) &&
                 (wordB.opcode == ats21IsaPkg::opSetMode);
    crossClash = (wordA.target == wordB.target) &&
                 (((wordA.opcode == ats21IsaPkg::opSetAlarm) &&
                   (wordB.opcode == ats21IsaPkg::opSetTimer)) ||
                  ((wordA.opcode == ats21IsaPkg::opSetTimer) &&
                   (wordB.opcode == ats21IsaPkg::opSetAlarm)));
    conflict   = validA && validB && (clockClash || alarmClash || modeClash || crossClash);
  end

  assign cmdA = formCmd(wordA, validA, mode.clockPermA, mode.alarmPermA, conflict, baseA);
  assign cmdB = formCmd(wordB, validB, mode.clockPermB, mode.alarmPermB, conflict, baseB);

endmodule

//--- rtl/modeStatus.sv
module modeStatus (
  input  logic                    clk_1x,
  input  logic                    reset,
  input  ats21IsaPkg::clientCmdT  cmdA,
  input  ats21IsaPkg::clientCmdT  cmdB,
  input  logic                    busyA,
  input  logic                    busyB,
  output ats21StatePkg::modeT     mode,
  output logic [1:0]              stat,
  output logic                    ready
);

  logic modeWrA, modeWrB;

  // both at once is a conflict, so never together
  assign modeWrA = cmdA.accepted && (cmdA.opcode == ats21IsaPkg::opSetMode);
  assign modeWrB = cmdB.accepted && (cmdB.opcode == ats21IsaPkg::opSetMode);

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      mode <= '1;  // active, all permissions granted
      stat <= '0;
    end else begin
      if (modeWrA) begin
        mode.active     <= cmdA.flag;
        mode.clockPermA <= cmdA.alarmIdx[ats21IsaPkg::modeClockPermBit];
        mode.alarmPermA <= cmdA.alarmIdx[ats21IsaPkg::modeAlarmPermBit];
      end
      if (modeWrB) begin
        mode.active     <= cmdB.flag;
        mode.clockPermB <= cmdB.alarmIdx[ats21IsaPkg::modeClockPermBit];
        mode.alarmPermB <= cmdB.alarmIdx[ats21IsaPkg::modeAlarmPermBit];
      end
      // lower-half edge of either client, held until the next one
      if (busyA || busyB) begin
        stat[ats21StatePkg::clientA] <= cmdA.accepted;
        stat[ats21StatePkg::clientB] <= cmdB.accepted;
      end
    end
  end

  assign ready = !(busyA || busyB);  // low while an upper half is held

endmodule

//--- timebase/clockBank.sv
module clockBank #(
  parameter int numClocks    = 16,
  parameter int counterWidth = 16
) (
  input  logic                                   clk_1x,
  input  logic                                   reset,
  input  ats21IsaPkg::clientCmdT                 cmdA,
  input  ats21IsaPkg::clientCmdT                 cmdB,
  input  logic                                   active,
  output logic [numClocks-1:0][counterWidth-1:0] counts,
  output ats21StatePkg::rateT [numClocks-1:0]    rates,
  output ats21StatePkg::tickT                    ticks
);

  typedef struct packed {
    logic                    enable;
    ats21StatePkg::rateT     rate;
    logic [counterWidth-1:0] count;
  } clockT;

  clockT [numClocks-1:0] clocks;
  logic [1:0]            phase;  // free running from reset

  // rate enables, no derived clocks
  assign ticks.x1   = 1'b1;
  assign ticks.div2 = phase[0];  // every 2nd cycle
  assign ticks.div4 = &phase;    // every 4th cycle

  function automatic clockT applyCmd(clockT cl, ats21IsaPkg::clientCmdT c, int idx);
    if (c.accepted && (int'(c.clockIdx) == idx)) begin
      case (c.opcode)
        ats21IsaPkg::opSetClock: begin
          cl.enable = 1'b1;
          cl.rate   = ats21StatePkg::rateT'(c.rate);
          cl.count  = c.value[counterWidth-1:0];
        end
        ats21IsaPkg::opEnClock: cl.enable = c.flag;  // enable bit only
        default: ;
      endcase
    end
    return cl;
  endfunction

  always_ff @(posedge clk_1x or posedge reset) begin
    clockT nextClk;
    if (reset) begin
      phase  <= '0;
      clocks <= '0;
    end else begin
      phase <= phase + 2'd1;
      for (int i = 0; i < numClocks; i++) begin
        nextClk = clocks[i];
        if (nextClk.enable && ats21StatePkg::rateTick(nextClk.rate, ticks)) begin
          nextClk.count = nextClk.count + 1'b1;  // wraps
        end
        nextClk = applyCmd(nextClk, cmdA, i);  // commands override the count
        nextClk = applyCmd(nextClk, cmdB, i);
        if (!active) begin
          nextClk.enable = 1'b0;  // inactive device stops every clock
        end
        clocks[i] <= nextClk;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < numClocks; i++) begin
      counts[i] = clocks[i].count;
      rates[i]  = clocks[i].rate;
    end
  end

endmodule

//--- timebase/alarmBank.sv
module alarmBank #(
  parameter int numClocks    = 16,
  parameter int numAlarms    = 24,
  parameter int counterWidth = 16
) (
  input  logic                                   clk_1x,
  input  logic                                   reset,
  input  ats21IsaPkg::clientCmdT                 cmdA,
  input  ats21IsaPkg::clientCmdT                 cmdB,
  input  logic [numClocks-1:0][counterWidth-1:0] counts,
  input  ats21StatePkg::tickT                    ticks,
  input  logic                                   active,
  input  ats21StatePkg::rateT [numClocks-1:0]    rates,
  output logic [numAlarms-1:0]                   data
);

  typedef struct packed {
    logic                             enable;
    logic                             countdown;      // timer, never repeats
    logic                             loop;
    logic [ats21IsaPkg::clockIdxW-1:0] assignedClock;
    logic [counterWidth-1:0]          value;
    logic [1:0]                       hold;           // finished cycles left
  } alarmT;

  alarmT [numAlarms-1:0] alarms;
  logic  [numAlarms-1:0] match;

  ////////////////////////////////////////////////////////////////////////////
  // match, same rule at every rate
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < numAlarms; i++) begin
      match[i] = alarms[i].enable && active &&
                 ats21StatePkg::rateTick(rates[alarms[i].assignedClock], ticks) &&
                 (counterWidth'(counts[alarms[i].assignedClock] + 1'b1) == alarms[i].value);
    end
  end

  function automatic alarmT applyCmd(alarmT a, ats21IsaPkg::clientCmdT c, int idx);
    if (c.accepted && (int'(c.alarmIdx) == idx)) begin
      case (c.opcode)
        ats21IsaPkg::opSetAlarm, ats21IsaPkg::opSetTimer: begin
          a.enable        = 1'b1;  // armed when set
          a.countdown     = (c.opcode == ats21IsaPkg::opSetTimer);
          a.loop          = c.flag;
          a.assignedClock = c.clockSel;
          a.value         = c.value[counterWidth-1:0];
        end
        ats21IsaPkg::opEnAlarm: a.enable = c.flag;
        default: ;
      endcase
    end
    return a;
  endfunction

  always_ff @(posedge clk_1x or posedge reset) begin
    alarmT nextAlm;
    if (reset) begin
      alarms <= '0;
    end else begin
      for (int i = 0; i < numAlarms; i++) begin
        nextAlm = alarms[i];
        if (nextAlm.hold != 2'd0) begin
          nextAlm.hold = nextAlm.hold - 2'd1;
        end
        if (match[i]) begin
          nextAlm.hold = 2'd2;  // data high for two cycles
          if (!(nextAlm.loop && !nextAlm.countdown)) begin
            nextAlm.enable = 1'b0;  // one-shot and timers disarm
          end
        end
        nextAlm = applyCmd(nextAlm, cmdA, i);
        nextAlm = applyCmd(nextAlm, cmdB, i);
        if (!active) begin
          nextAlm.enable = 1'b0;
        end
        alarms[i] <= nextAlm;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < numAlarms; i++) begin
      data[i] = |alarms[i].hold;  // per-alarm finished
    end
  end

endmodule

//--- rtl/ats21Top.sv
module ats21Top #(
  parameter int numClocks    = 16,  // up to 16
  parameter int numAlarms    = 24,  // up to 24
  parameter int counterWidth = 16
) (
  input  logic                           clk_1x,
  input  logic                           reset,
  input  logic                           req,
  input  logic [ats21IsaPkg::beatW-1:0]  ctrlA,
  input  logic [ats21IsaPkg::beatW-1:0]  ctrlB,
  output logic                           ready,
  output logic [1:0]                     stat,   // bit 0 client A, 1 = Ack
  output logic [numAlarms-1:0]           data
);

  ats21IsaPkg::instWordT  wordA, wordB;
  logic                   validA, validB;
  logic                   busyA, busyB;
  ats21IsaPkg::clientCmdT cmdA, cmdB;
  ats21StatePkg::modeT    mode;
  ats21StatePkg::tickT    ticks;

  logic [numClocks-1:0][counterWidth-1:0] counts;
  ats21StatePkg::rateT [numClocks-1:0]    rates;

  ////////////////////////////////////////////////////////////////////////////
  // decode side
  ////////////////////////////////////////////////////////////////////////////

  clientCapture captureA (
    .clk_1x, .reset, .req, .beat(ctrlA),
    .word(wordA), .wordValid(validA), .busy(busyA)
  );

  clientCapture captureB (
    .clk_1x, .reset, .req, .beat(ctrlB),
    .word(wordB), .wordValid(validB), .busy(busyB)
  );

  instDecode #(.numClocks(numClocks), .counterWidth(counterWidth)) decode (
    .wordA, .wordB, .validA, .validB, .mode, .counts, .cmdA, .cmdB
  );

  // result side
  modeStatus status (
    .clk_1x, .reset, .cmdA, .cmdB, .busyA, .busyB, .mode, .stat, .ready
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute side
  ////////////////////////////////////////////////////////////////////////////

  clockBank #(.numClocks(numClocks), .counterWidth(counterWidth)) clocks (
    .clk_1x, .reset, .cmdA, .cmdB, .active(mode.active),
    .counts, .rates, .ticks
  );

  alarmBank #(
    .numClocks(numClocks), .numAlarms(numAlarms), .counterWidth(counterWidth)
  ) alarms (
    .clk_1x, .reset, .cmdA, .cmdB, .counts, .ticks,
    .active(mode.active), .rates, .data
  );

endmodule

//--- tb/ats21TbTasks.svh
////////////////////////////////////////////////////////////////////////////
// instruction encoding, field layout from the ISA
////////////////////////////////////////////////////////////////////////////

localparam logic [2:0] opSetClock = 3'b001;
localparam logic [2:0] opSetMode  = 3'b011;
localparam logic [2:0] opSetAlarm = 3'b101;
localparam logic [2:0] opSetTimer = 3'b110;
localparam logic [2:0] opEnAlarm  = 3'b111;

// clock number sits in the top four target bits, rate in 23:22
function automatic logic [31:0] clockWord(int clk, logic [1:0] rate, int count);
  return {opSetClock, 4'(clk), 1'b0, rate, 2'b00, 4'b0000, 16'(count)};
endfunction

function automatic logic [31:0] alarmWord(logic [2:0] op, int alarm, logic flag, int clk,
                                          int value);
  return {op, 5'(alarm), flag, 1'b0, 2'b00, 4'(clk), 16'(value)};
endfunction

// bit 27 clock permission, bit 25 alarm permission, bit 23 active
function automatic logic [31:0] modeWord(logic active, logic clockPerm, logic alarmPerm);
  return {opSetMode, 1'b0, clockPerm, 1'b0, alarmPerm, 1'b0, active, 1'b0, 22'h0};
endfunction

task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
  assert (actual === expected) else begin
    $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    errorCount++;
  end
endtask

task automatic checkRange(input int actual, input int lo, input int hi, input string what);
  assert ((actual >= lo) && (actual <= hi)) else begin
    $display("[ERROR] %0t: %s is %0d, expected %0d..%0d", $time, what, actual, lo, hi);
    errorCount++;
  end
endtask

////////////////////////////////////////////////////////////////////////////
// two-beat transfer, both clients in the same cycles
////////////////////////////////////////////////////////////////////////////

task automatic sendInst(input logic [31:0] instA, input logic [31:0] instB);
  int waited;
  @(posedge clk_1x);
  req   <= 1'b1;
  ctrlA <= instA[31:16];  // zero upper bits mean Nop
  ctrlB <= instB[31:16];
  @(posedge clk_1x);      // upper halves taken
  req   <= 1'b0;
  ctrlA <= instA[15:0];
  ctrlB <= instB[15:0];
  @(negedge clk_1x);
  checkEq(ready, 1'b0, "ready between beats");
  @(posedge clk_1x);      // lower halves taken, state and stat update here
  ctrlA <= '0;
  ctrlB <= '0;
  @(negedge clk_1x);
  doneCycle = cycle;
  waited = 0;
  while (!ready && (waited < 8)) begin
    @(negedge clk_1x);
    waited++;
  end
  if (!ready) begin
    $display("ready never came back high after the lower half at time %0t", $time);
    errorCount++;
  end
endtask

// first rise, last rise, width of the first pulse and pulse count
task automatic watchData(input int idx, input int span, output int firstRise,
                         output int lastRise, output int firstWidth, output int pulses);
  logic prev;
  prev       = 1'b0;
  firstRise  = -1;
  lastRise   = -1;
  firstWidth = 0;
  pulses     = 0;
  repeat (span) begin
    @(negedge clk_1x);
    if (data[idx] && !prev) begin
      pulses++;
      lastRise = cycle;
      if (pulses == 1) firstRise = cycle;
    end
    if (data[idx] && (pulses == 1)) firstWidth++;
    prev = data[idx];
  end
endtask

task automatic endTest(input string name, input int errorsAtStart);
  testCount++;
  if (errorCount != errorsAtStart) begin
    failedTests++;
    $display("test %s: failed", name);
  end else begin
    $display("test %s: ok", name);
  end
endtask

//--- tb/ats21Tb.sv
module ats21Tb;

  localparam int numClocks      = 16;
  localparam int numAlarms      = 24;
  localparam int wrapSpan       = 300;                // one 8-bit wrap at 1x plus margin
  localparam int watchdogCycles = 8 * wrapSpan + 600; // test windows summed with margin

  logic                 clk_1x, reset, req, ready;
  logic [15:0]          ctrlA, ctrlB;
  logic [1:0]           stat;
  logic [numAlarms-1:0] data;

  integer seed = 52254;
  int cycle = 0;
  int doneCycle, clkDone, errorCount = 0, testCount = 0, failedTests = 0, testErrors;
  int clk1, clk2, alm1, alm2, base, k1, k2, interval, quietHits;
  int rise1, last1, width1, pulses1, rise2, last2, width2, pulses2;

  ats21Top #(.numClocks(numClocks), .numAlarms(numAlarms), .counterWidth(8)) ats21Top_inst (
    .clk_1x, .reset, .req, .ctrlA, .ctrlB, .ready, .stat, .data
  );

  `include "ats21TbTasks.svh"

  initial begin
    clk_1x = 1'b0;
    forever #20 clk_1x = ~clk_1x;
  end

  always @(posedge clk_1x) cycle <= cycle + 1;  // read at negedge only

  initial begin
    repeat (watchdogCycles) @(posedge clk_1x);
    $display("watchdog expired after %0d cycles, test sequence hung", watchdogCycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    reset = 1'b1;
    req   = 1'b0;
    ctrlA = '0;
    ctrlB = '0;
    repeat (10) @(posedge clk_1x);
    reset <= 1'b0;
    @(negedge clk_1x);
    testErrors = errorCount;
    checkEq(ready, 1'b1, "ready after reset");
    checkEq(stat, 2'b00, "stat after reset");
    checkEq(data, '0, "data after reset");
    endTest("reset", testErrors);

    //////////////////////////////////////////////////////////////////////////
    // alarms on a 1x clock whose count wraps every 256 cycles
    //////////////////////////////////////////////////////////////////////////
    testErrors = errorCount;
    clk1 = $unsigned($random(seed)) % numClocks;
    alm1 = $unsigned($random(seed)) % numAlarms;
    base = $unsigned($random(seed)) % 256;
    k1   = 8 + $unsigned($random(seed)) % 16;  // past the alarm write
    sendInst(clockWord(clk1, 2'b00, base), 32'h0);
    checkEq(stat, 2'b01, "stat for set clock");  // B sent Nop
    clkDone = doneCycle;
    sendInst(alarmWord(opSetAlarm, alm1, 1'b0, clk1, base + k1), 32'h0);
    checkEq(stat, 2'b01, "stat for one-shot alarm");
    watchData(alm1, wrapSpan, rise1, last1, width1, pulses1);
    checkEq(rise1, clkDone + k1, "one-shot rise cycle");
    checkEq(width1, 2, "one-shot pulse width");
    checkEq(pulses1, 1, "one-shot pulse count");
    endTest("oneShotAlarm", testErrors);

    testErrors = errorCount;
    clk2 = $unsigned($random(seed)) % numClocks;
    alm2 = $unsigned($random(seed)) % numAlarms;
    k2   = 8 + $unsigned($random(seed)) % 16;
    sendInst(clockWord(clk2, 2'b00, base), 32'h0);
    clkDone = doneCycle;
    sendInst(alarmWord(opSetAlarm, alm2, 1'b1, clk2, base + k2), 32'h0);
    checkEq(stat, 2'b01, "stat for repeating alarm");
    watchData(alm2, wrapSpan, rise1, last1, width1, pulses1);
    checkEq(rise1, clkDone + k2, "repeating first rise cycle");
    checkEq(width1, 2, "repeating pulse width");
    checkEq(pulses1, 2, "repeating pulse count");
    checkEq(last1 - rise1, 256, "repeat period");
    sendInst(alarmWord(opEnAlarm, alm2, 1'b0, 0, 0), 32'h0);  // disable
    checkEq(stat, 2'b01, "stat for alarm disable");
    watchData(alm2, wrapSpan, rise1, last1, width1, pulses1);
    checkEq(pulses1, 0, "pulses after disable");
    endTest("repeatAlarm", testErrors);

    // countdown on a /4 clock
    testErrors = errorCount;
    interval = 5 + $unsigned($random(seed)) % 10;
    sendInst(clockWord(clk1, 2'b10, $unsigned($random(seed)) % 256), 32'h0);
    sendInst(alarmWord(opSetTimer, alm1, 1'b0, clk1, interval), 32'h0);
    checkEq(stat, 2'b01, "stat for timer");
    clkDone = doneCycle;
    watchData(alm1, 4 * interval + 40, rise1, last1, width1, pulses1);
    checkRange(rise1 - clkDone, 4 * interval - 4, 4 * interval + 4, "timer delay");
    checkEq(width1, 2, "timer pulse width");
    checkEq(pulses1, 1, "timer pulse count");
    endTest("countdownTimer", testErrors);

    //////////////////////////////////////////////////////////////////////////
    // both clients at once
    //////////////////////////////////////////////////////////////////////////
    testErrors = errorCount;
    alm2 = (alm1 + 1 + $unsigned($random(seed)) % (numAlarms - 1)) % numAlarms;
    sendInst(alarmWord(opSetAlarm, alm1, 1'b0, clk2, 0),
             alarmWord(opSetAlarm, alm1, 1'b0, clk2, 0));
    checkEq(stat, 2'b00, "stat for same alarm twice");
    sendInst(alarmWord(opSetAlarm, alm1, 1'b0, clk2, 0),
             alarmWord(opSetTimer, alm1, 1'b0, clk2, 5));
    checkEq(stat, 2'b00, "stat for alarm and timer on one alarm");
    sendInst(clockWord(clk2, 2'b00, base), 32'h0);
    clkDone = doneCycle;
    sendInst(alarmWord(opSetAlarm, alm1, 1'b0, clk2, base + 12),
             alarmWord(opSetAlarm, alm2, 1'b0, clk2, base + 16));
    checkEq(stat, 2'b11, "stat for different alarms");
    fork
      watchData(alm1, 40, rise1, last1, width1, pulses1);
      watchData(alm2, 40, rise2, last2, width2, pulses2);
    join
    checkEq(rise1, clkDone + 12, "client A alarm rise cycle");
    checkEq(rise2, clkDone + 16, "client B alarm rise cycle");
    checkEq(width1, 2, "client A alarm pulse width");
    checkEq(width2, 2, "client B alarm pulse width");
    checkEq(pulses1 + pulses2, 2, "pulse count for both alarms");
    endTest("conflicts", testErrors);

    // A drops its clock permission while B keeps its own
    testErrors = errorCount;
    clk2 = (clk1 + 1 + $unsigned($random(seed)) % (numClocks - 1)) % numClocks;
    sendInst(modeWord(1'b1, 1'b0, 1'b1), 32'h0);
    checkEq(stat, 2'b01, "stat for set mode");
    sendInst(clockWord(clk1, 2'b00, 0), clockWord(clk2, 2'b00, 0));
    checkEq(stat, 2'b10, "stat for set clock without permission");
    endTest("modePermission", testErrors);

    testErrors = errorCount;
    sendInst(32'h0, clockWord(clk2, 2'b00, base));
    sendInst(alarmWord(opSetAlarm, alm1, 1'b1, clk2, base + 24), 32'h0);  // pending
    checkEq(stat, 2'b01, "stat for pending alarm");
    sendInst(modeWord(1'b0, 1'b0, 1'b1), 32'h0);  // device inactive
    checkEq(stat, 2'b01, "stat for inactive mode");
    quietHits = 0;
    repeat (wrapSpan) begin
      @(negedge clk_1x);
      if (data !== '0) quietHits++;
    end
    checkEq(quietHits, 0, "cycles with data high while inactive");
    endTest("modeInactive", testErrors);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- ats21.f
+incdir+tb
common/ats21IsaPkg.sv
common/ats21StatePkg.sv
rtl/clientCapture.sv
rtl/instDecode.sv
rtl/modeStatus.sv
timebase/clockBank.sv
timebase/alarmBank.sv
rtl/ats21Top.sv
tb/ats21Tb.sv
